/* src/scope_pkg.sv */
/* scope_pkg
   shared VGA timing, grid and trace constants, sample and capture types */

`default_nettype none

package scope_pkg;

   // horizontal timing in pixels
   localparam int h_visible = 640;
   localparam int h_front   = 16;
   localparam int h_sync    = 96;
   localparam int h_total   = 800;

   // vertical timing in lines
   localparam int v_visible = 480;
   localparam int v_front   = 10;
   localparam int v_sync    = 2;
   localparam int v_total   = 525;

   // grid spacing
   localparam int grid_x_step = 64;
   localparam int grid_y_step = 60;

   // trace geometry, row of sample value 0
   localparam int trace_len  = 256;
   localparam int trace_base = 400;

   localparam logic [11:0] colour_grid  = 12'h444;
   localparam logic [11:0] colour_level = 12'hF00;
   localparam logic [11:0] colour_trace = 12'h0F0;
   localparam logic [11:0] colour_back  = 12'h000;

   typedef logic [11:0] sample_t;

   typedef enum logic [1:0] {armed, capturing, holding} capture_state_t;

   // screen row of a sample value, top 8 bits only
   function automatic logic [10:0] sample_row(sample_t s);
      return 11'(trace_base) - 11'(s >> 4);
   endfunction

endpackage

`default_nettype wire

/* src/vga_if.sv */
/* vga_if
   pixel position, sync, blanking and colour passed between pixel stages */

`timescale 1ns/1ps
`default_nettype none

interface vga_if;
   logic [10:0] hcount;
   logic [10:0] vcount;
   logic        hsync;
   logic        vsync;
   logic        hblnk;
   logic        vblnk;
   logic [11:0] rgb;

   // producer side
   modport out (output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);
   // consumer side
   modport in (input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);
endinterface

`default_nettype wire

/* src/vga_timing.sv */
/* vga_timing
   640x480 at 60 Hz counters with sync, blanking and a frame-start pulse */

`timescale 1ns/1ps
`default_nettype none

module vga_timing (
   input  logic clk,
   input  logic rst_n,
   vga_if.out   out,
   output logic frame_start
);
   import scope_pkg::*;

   logic [10:0] hcount;
   logic [10:0] vcount;
   logic        line_end;
   logic        frame_end;

   // last pixel of a line, last line of a frame
   assign line_end  = (hcount == 11'(h_total - 1));
   assign frame_end = line_end && (vcount == 11'(v_total - 1));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hcount      <= '0;
         vcount      <= '0;
         frame_start <= 1'b0;
      end else begin
         // pulse lines up with both counters at 0
         frame_start <= frame_end;
         if (line_end) begin
            hcount <= '0;
            if (frame_end) begin
               vcount <= '0;
            end else begin
               vcount <= vcount + 11'd1;
            end
         end else begin
            hcount <= hcount + 11'd1;
         end
      end
   end

   assign out.hcount = hcount;
   assign out.vcount = vcount;

   // blanking past the visible area
   assign out.hblnk = (hcount >= 11'(h_visible));
   assign out.vblnk = (vcount >= 11'(v_visible));

   // sync active low inside its window
   assign out.hsync = !((hcount >= 11'(h_visible + h_front)) &&
                        (hcount <  11'(h_visible + h_front + h_sync)));
   assign out.vsync = !((vcount >= 11'(v_visible + v_front)) &&
                        (vcount <  11'(v_visible + v_front + v_sync)));

   // no colour at the source
   assign out.rgb = 12'h000;

endmodule

`default_nettype wire

/* src/trigger_capture.sv */
/* trigger_capture
   rising-edge trigger, capture FSM and 256-entry sample buffer */

`timescale 1ns/1ps
`default_nettype none

module trigger_capture (
   input  logic               clk,
   input  logic               rst_n,
   input  scope_pkg::sample_t sample,
   input  logic               sample_valid,
   output logic               sample_ready,
   input  scope_pkg::sample_t trigger_level,
   input  logic               frame_start,
   input  logic [7:0]         rd_addr,
   output scope_pkg::sample_t rd_data,
   output logic               has_capture
);
   import scope_pkg::*;

   capture_state_t state;
   logic [7:0]     wr_ptr;
   logic [7:0]     wr_addr;
   logic           prev_below;
   logic           accept;
   logic           crossing;
   logic           wr_en;
   sample_t        buffer [trace_len];

   // back-pressure only while holding
   assign sample_ready = (state != holding);
   assign accept       = sample_valid && sample_ready;

   // previous sample below, this one at or above
   assign crossing = prev_below && (sample >= trigger_level);

   // trigger sample lands at 0, the rest follow the pointer
   assign wr_en   = accept && ((state == capturing) || ((state == armed) && crossing));
   assign wr_addr = (state == armed) ? 8'd0 : wr_ptr;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state       <= armed;
         wr_ptr      <= '0;
         prev_below  <= 1'b0;
         has_capture <= 1'b0;
      end else begin
         if (accept) begin
            prev_below <= (sample < trigger_level);
         end
         case (state)
            armed: begin
               if (accept && crossing) begin
                  state  <= capturing;
                  wr_ptr <= 8'd1;
               end
            end
            capturing: begin
               if (accept) begin
                  wr_ptr <= wr_ptr + 8'd1;
                  // 256th sample written
                  if (wr_ptr == 8'(trace_len - 1)) begin
                     state       <= holding;
                     has_capture <= 1'b1;
                  end
               end
            end
            holding: begin
               // rearm on the next frame
               if (frame_start) begin
                  state <= armed;
               end
            end
            default: state <= armed;
         endcase
      end
   end

   // buffer write and registered read port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         buffer[wr_addr] <= sample;
      end
      rd_data <= buffer[rd_addr];
   end

endmodule

`default_nettype wire

/* src/draw_grid.sv */
/* draw_grid
   background, grid lines and trigger-level row, one register stage */

`timescale 1ns/1ps
`default_nettype none

module draw_grid (
   input  logic               clk,
   input  logic               rst_n,
   vga_if.in                  in,
   vga_if.out                 out,
   input  scope_pkg::sample_t trigger_level
);
   import scope_pkg::*;

   logic [10:0] level_row;
   logic [11:0] rgb_nxt;

   // same mapping as a drawn sample
   assign level_row = sample_row(trigger_level);

   always_comb begin
      if (in.hblnk || in.vblnk) begin
         rgb_nxt = 12'h000;
      end else if (in.vcount == level_row) begin
         rgb_nxt = colour_level;
      end else if ((in.hcount % grid_x_step == 0) || (in.vcount % grid_y_step == 0)) begin
         rgb_nxt = colour_grid;
      end else begin
         rgb_nxt = colour_back;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out.hcount <= '0;
         out.vcount <= '0;
         // sync idles high
         out.hsync  <= 1'b1;
         out.vsync  <= 1'b1;
         out.hblnk  <= 1'b0;
         out.vblnk  <= 1'b0;
         out.rgb    <= '0;
      end else begin
         out.hcount <= in.hcount;
         out.vcount <= in.vcount;
         out.hsync  <= in.hsync;
         out.vsync  <= in.vsync;
         out.hblnk  <= in.hblnk;
         out.vblnk  <= in.vblnk;
         out.rgb    <= rgb_nxt;
      end
   end

endmodule

`default_nettype wire

/* src/draw_trace.sv */
/* draw_trace
   reads the capture buffer by column and paints the trace over the grid */

`timescale 1ns/1ps
`default_nettype none

module draw_trace (
   input  logic               clk,
   input  logic               rst_n,
   vga_if.in                  in,
   vga_if.out                 out,
   output logic [7:0]         rd_addr,
   input  scope_pkg::sample_t rd_data,
   input  logic               has_capture
);
   import scope_pkg::*;

   logic [10:0] hcount_d;
   logic [10:0] vcount_d;
   logic        hsync_d;
   logic        vsync_d;
   logic        hblnk_d;
   logic        vblnk_d;
   logic [11:0] rgb_d;
   logic        hit;

   // column selects the sample, data returns next clock
   assign rd_addr = in.hcount[7:0];

   // delay the pixel by the read latency
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hcount_d <= '0;
         vcount_d <= '0;
         hsync_d  <= 1'b1;
         vsync_d  <= 1'b1;
         hblnk_d  <= 1'b0;
         vblnk_d  <= 1'b0;
         rgb_d    <= '0;
      end else begin
         hcount_d <= in.hcount;
         vcount_d <= in.vcount;
         hsync_d  <= in.hsync;
         vsync_d  <= in.vsync;
         hblnk_d  <= in.hblnk;
         vblnk_d  <= in.vblnk;
         rgb_d    <= in.rgb;
      end
   end

   // trace pixel: captured, visible, inside trace width, on the sample row
   assign hit = has_capture && !hblnk_d && !vblnk_d &&
                (hcount_d < 11'(trace_len)) &&
                (vcount_d == sample_row(rd_data));

   assign out.hcount = hcount_d;
   assign out.vcount = vcount_d;
   assign out.hsync  = hsync_d;
   assign out.vsync  = vsync_d;
   assign out.hblnk  = hblnk_d;
   assign out.vblnk  = vblnk_d;
   // otherwise grid colour passes through
   assign out.rgb    = hit ? colour_trace : rgb_d;

endmodule

`default_nettype wire

/* src/top_scope.sv */
/* top_scope
   VGA scope display: timing, grid and trace stages fed by the trigger buffer */

`timescale 1ns/1ps
`default_nettype none

module top_scope (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [11:0] sample,
   input  logic        sample_valid,
   output logic        sample_ready,
   input  logic [11:0] trigger_level,
   output logic        hs,
   output logic        vs,
   output logic [3:0]  r,
   output logic [3:0]  g,
   output logic [3:0]  b
);

   logic        frame_start;
   logic [7:0]  rd_addr;
   logic [11:0] rd_data;
   logic        has_capture;

   // stage links
   vga_if tim_bus ();
   vga_if grid_bus ();
   vga_if trace_bus ();

   // pins two clocks behind the counters
   assign hs        = trace_bus.hsync;
   assign vs        = trace_bus.vsync;
   assign {r, g, b} = trace_bus.rgb;

   vga_timing u_vga_timing (
      .clk,
      .rst_n,
      .out(tim_bus),
      .frame_start
   );

   trigger_capture u_trigger_capture (
      .clk,
      .rst_n,
      .sample,
      .sample_valid,
      .sample_ready,
      .trigger_level,
      .frame_start,
      .rd_addr,
      .rd_data,
      .has_capture
   );

   draw_grid u_draw_grid (
      .clk,
      .rst_n,
      .in(tim_bus),
      .out(grid_bus),
      .trigger_level
   );

   draw_trace u_draw_trace (
      .clk,
      .rst_n,
      .in(grid_bus),
      .out(trace_bus),
      .rd_addr,
      .rd_data,
      .has_capture
   );

endmodule

`default_nettype wire

/* testbench/top_scope_properties.sv */
/* top_scope_properties
   sync timing, blanking, sample handshake and trace checks bound into top_scope */

`timescale 1ns/1ps
`default_nettype none

module top_scope_properties (
   input logic        clk,
   input logic        rst_n,
   input logic        hs,
   input logic        vs,
   input logic [3:0]  r,
   input logic [3:0]  g,
   input logic [3:0]  b,
   input logic [11:0] sample,
   input logic        sample_valid,
   input logic        sample_ready,
   input logic        frame_start,
   input logic        has_capture
);
   import scope_pkg::*;

   logic        hs_q;
   logic        vs_q;
   logic        reset_q;
   logic        h_seen;
   logic        v_seen;
   logic [9:0]  hs_cnt;
   logic [18:0] vs_cnt;
   logic        h_blank;
   logic        v_blank;

   // clocks since the last sync fall, restarted at 1 on the fall
   always_ff @(posedge clk) begin
      reset_q <= !rst_n;
      if (!rst_n) begin
         hs_q   <= 1'b1;
         vs_q   <= 1'b1;
         h_seen <= 1'b0;
         v_seen <= 1'b0;
         hs_cnt <= '0;
         vs_cnt <= '0;
      end else begin
         hs_q   <= hs;
         vs_q   <= vs;
         hs_cnt <= (hs_q && !hs) ? 10'd1 : hs_cnt + 10'd1;
         vs_cnt <= (vs_q && !vs) ? 19'd1 : vs_cnt + 19'd1;
         if (hs_q && !hs) begin
            h_seen <= 1'b1;
         end
         if (vs_q && !vs) begin
            v_seen <= 1'b1;
         end
      end
   end

   // hs falls at column 656, vs at column 0 of row 490
   assign h_blank = (hs_cnt < 10'(h_total - h_visible - h_front)) ||
                    (hs_cnt >= 10'(h_total - h_front));
   assign v_blank = (vs_cnt < 19'((v_total - v_visible - v_front) * h_total)) ||
                    (vs_cnt >= 19'((v_total - v_front) * h_total));

   assert property (@(posedge clk) disable iff (!rst_n)
      (h_seen && !hs_q && hs) |-> (hs_cnt == 10'(h_sync)))
      else $error("hs low pulse length wrong");
   assert property (@(posedge clk) disable iff (!rst_n)
      (h_seen && hs_q && !hs) |-> (hs_cnt == 10'(h_total)))
      else $error("hs period wrong");
   assert property (@(posedge clk) disable iff (!rst_n)
      (v_seen && !vs_q && vs) |-> (vs_cnt == 19'(v_sync * h_total)))
      else $error("vs low pulse length wrong");
   assert property (@(posedge clk) disable iff (!rst_n)
      (v_seen && vs_q && !vs) |-> (vs_cnt == 19'(v_total * h_total)))
      else $error("vs period wrong");

   // sync idle while reset is held
   assert property (@(posedge clk) (!rst_n && reset_q) |-> (hs && vs))
      else $error("sync active during reset");

   assert property (@(posedge clk) disable iff (!rst_n)
      (h_seen && v_seen && (h_blank || v_blank)) |-> ({r, g, b} == 12'h000))
      else $error("colour outside the visible area");

   // source holds its sample under back-pressure
   assert property (@(posedge clk) disable iff (!rst_n)
      (sample_valid && !sample_ready) |=> $stable(sample))
      else $error("sample changed while not ready");
   assert property (@(posedge clk) disable iff (!rst_n)
      (!sample_ready && !frame_start) |=> !sample_ready)
      else $error("ready rose without a frame start");
   assert property (@(posedge clk) disable iff (!rst_n)
      (!sample_ready && frame_start) |=> sample_ready)
      else $error("ready stayed low after frame start");
   assert property (@(posedge clk) disable iff (!rst_n)
      !sample_ready |-> has_capture)
      else $error("back-pressure without a finished capture");

   // trace only once a capture exists, and it never clears
   assert property (@(posedge clk) disable iff (!rst_n)
      has_capture |=> has_capture)
      else $error("has_capture cleared");
   assert property (@(posedge clk) disable iff (!rst_n)
      ({r, g, b} == colour_trace) |-> has_capture)
      else $error("trace colour before any capture");

endmodule

`default_nettype wire

/* testbench/tb_top_scope.sv */
/* tb_top_scope
   drives noise and trigger steps into the scope, tracks the pixel position
   from the sync pins and compares every visible pixel with the expected colour */

`timescale 1ns/1ps
`default_nettype none

module tb_top_scope;
   import scope_pkg::*;

   logic        clk = 1'b0;
   logic        rst_n;
   logic [11:0] sample;
   logic        sample_valid;
   logic        sample_ready;
   logic [11:0] trigger_level;
   logic        hs;
   logic        vs;
   logic [3:0]  r;
   logic [3:0]  g;
   logic [3:0]  b;

   // pixel tracking from the pins
   int          px_x;
   int          px_y;
   logic        hs_q;
   logic        vs_q;
   logic        h_lock;
   logic        v_lock;

   // test state
   logic [31:0] rand_state;
   logic        noise_on;
   logic        count_en;
   logic        check_en;
   logic        idle_phase;
   logic        exp_trace;
   int          exp_row;
   int          accepts;
   int          errors;
   int          pix_checks;
   logic [11:0] exp_rgb;

   always #4 clk = ~clk;

   top_scope i_top_scope (
      .clk,
      .rst_n,
      .sample,
      .sample_valid,
      .sample_ready,
      .trigger_level,
      .hs,
      .vs,
      .r,
      .g,
      .b
   );

   bind top_scope top_scope_properties i_top_scope_properties (
      .clk(clk),
      .rst_n(rst_n),
      .hs(hs),
      .vs(vs),
      .r(r),
      .g(g),
      .b(b),
      .sample(sample),
      .sample_valid(sample_valid),
      .sample_ready(sample_ready),
      .frame_start(frame_start),
      .has_capture(has_capture)
   );

   function automatic logic [31:0] next_rand(logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // colour rules in priority order, trace over level over grid
   function automatic logic [11:0] expected_rgb(int x, int y);
      int level_row;
      level_row = trace_base - int'(trigger_level >> 4);
      if (x >= h_visible || y >= v_visible) return 12'h000;
      if (exp_trace && x < trace_len && y == exp_row) return colour_trace;
      if (y == level_row) return colour_level;
      if ((x % grid_x_step == 0) || (y % grid_y_step == 0)) return colour_grid;
      return colour_back;
   endfunction

   task automatic report_mismatch(string name, int expected, int actual);
      errors++;
      if (errors <= 10) begin
         $display("FAILED %s expected %0h actual %0h", name, expected, actual);
      end
   endtask

   task automatic report_error(string msg);
      errors++;
      if (errors <= 10) begin
         $display("%s", msg);
      end
   endtask

   // one clock, inputs change 1 ns after the edge
   task automatic step_clock();
      logic ready_before;
      ready_before = sample_ready;
      @(posedge clk);
      #1;
      // new noise only after the last one was taken
      if (noise_on && ready_before) begin
         rand_state = next_rand(rand_state);
         sample = 12'(rand_state[25:16]);
      end
   endtask

   task automatic wait_pixel(int x, int y);
      do step_clock(); while (!(h_lock && v_lock && px_x == x && px_y == y));
   endtask

   // noise, then a step to value held through the capture and the next frame
   task automatic run_capture(logic [11:0] value);
      check_en = 1'b0;
      noise_on = 1'b1;
      repeat (4) step_clock();
      noise_on = 1'b0;
      sample = value;
      accepts = 0;
      count_en = 1'b1;
      do step_clock(); while (sample_ready);
      count_en = 1'b0;
      assert (accepts == trace_len)
         else report_mismatch("capture_length", trace_len, accepts);
      do step_clock(); while (!sample_ready);
      // armed one clock after frame start, pins two clocks behind the counters
      assert (px_y * h_total + px_x == v_total * h_total - 2)
         else report_mismatch("rearm_pixel", v_total * h_total - 2, px_y * h_total + px_x);
      exp_trace = 1'b1;
      exp_row = trace_base - int'(value >> 4);
      check_en = 1'b1;
      wait_pixel(0, 0);
      wait_pixel(h_total - 1, v_total - 1);
   endtask

   // position, accept count and colour checks, away from the driving edge
   always @(negedge clk) begin
      if (!rst_n) begin
         px_x = 0;
         px_y = 0;
         hs_q = 1'b1;
         vs_q = 1'b1;
         h_lock = 1'b0;
         v_lock = 1'b0;
      end else begin
         // hs falls at column 656, vs at column 0 of row 490
         if (hs_q && !hs) begin
            px_x = h_visible + h_front;
            h_lock = 1'b1;
         end else begin
            px_x = (px_x == h_total - 1) ? 0 : px_x + 1;
         end
         if (vs_q && !vs) begin
            px_y = v_visible + v_front;
            v_lock = 1'b1;
         end else if (px_x == 0) begin
            px_y = (px_y == v_total - 1) ? 0 : px_y + 1;
         end
         hs_q = hs;
         vs_q = vs;
         if (count_en && sample_valid && sample_ready) begin
            accepts++;
         end
         if (idle_phase) begin
            assert (sample_ready)
               else report_error("sample_ready dropped while all samples stay below the level");
         end
         if (h_lock && v_lock && check_en) begin
            exp_rgb = expected_rgb(px_x, px_y);
            pix_checks++;
            assert ({r, g, b} == exp_rgb)
               else report_mismatch($sformatf("pixel_%0d_%0d", px_x, px_y),
                                    32'(exp_rgb), 32'({r, g, b}));
         end
      end
   end

   // six frames of test sequence plus one frame of margin
   initial begin
      #(7 * h_total * v_total * 8);
      $display("watchdog expired before the test sequence finished");
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      rst_n = 1'b0;
      sample = '0;
      sample_valid = 1'b0;
      trigger_level = 12'h800;
      rand_state = 32'he14e4e1b;
      noise_on = 1'b0;
      count_en = 1'b0;
      check_en = 1'b0;
      idle_phase = 1'b0;
      exp_trace = 1'b0;
      exp_row = 0;
      accepts = 0;
      errors = 0;
      pix_checks = 0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      // noise under the level, one full frame without a trace
      sample_valid = 1'b1;
      noise_on = 1'b1;
      idle_phase = 1'b1;
      check_en = 1'b1;
      wait_pixel(h_total - 1, v_total - 1);
      wait_pixel(h_total - 1, v_total - 1);
      idle_phase = 1'b0;
      // first capture, then a re-trigger to a new row
      run_capture(12'hA00);
      run_capture(12'hC80);
      $display("pixel checks %0d, errors %0d", pix_checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
src/scope_pkg.sv
src/vga_if.sv
src/vga_timing.sv
src/trigger_capture.sv
src/draw_grid.sv
src/draw_trace.sv
src/top_scope.sv
testbench/top_scope_properties.sv
testbench/tb_top_scope.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the scope testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top_scope \
   -f all.f -o sim_scope

output=$(./obj_dir/sim_scope 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "TESTS PASSED"; then
   exit 0
fi
exit 1
